// File: tb/operandStim.txt
# W reg data pcStep, S steps the pc, P expected pc, all hex
# I instr branch link rd A B C, expected operands in hex
# after reset
P 00000000
I E0813002 0 0 3 00000000 00000000 00000000
# data-processing reads
W 1 11111111 0
W 2 22222222 0
W 3 33333333 0
I E0813002 0 0 3 11111111 22222222 33333333
I E1A31002 0 0 1 33333333 22222222 11111111
# pc advance, then a write that wins over a step
S
S
S
P 0000000C
W F 00001000 1
P 00001000
S
P 00001004
# branches, forward and negative offsets
I EB000010 1 1 0 00001004 00000040 00000000
I EAFFFFFE 1 0 0 00001004 FFFFFFF8 00000000
I EA800000 1 0 0 00001004 FE000000 00000000
# back to back, then a write in the read cycle
I E1A31002 0 0 1 33333333 22222222 11111111
I EB000010 1 1 0 00001004 00000040 00000000
I E0813002 0 0 3 11111111 22222222 33333333
W 1 AAAAAAAA 0
I E0813002 0 0 3 AAAAAAAA 22222222 33333333
# pc step in the cycle of a branch read
I EB000010 1 1 0 00001004 00000040 00000000
S
P 00001008

// File: verilog.f
src/coreTypes.sv
src/decodeIf.sv
src/readPortIf.sv
src/regFile.sv
src/decodeStage.sv
src/executeLatch.sv
src/operandFetch.sv
tb/operandFetch_sva.sv
tb/operandFetchTb.sv

// File: run.sh
#!/bin/sh
# build the operand-fetch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module operandFetchTb -f verilog.f
if ! ./obj_dir/VoperandFetchTb > sim.log 2>&1
then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log
if grep -q '\*\* FAIL \*\*' sim.log
then
  exit 1
fi

// File: tb/operandFetchTb.sv
// testbench for the operand-fetch slice
// replays the stimulus file, checks every ex result in the cycle it is due
`timescale 1ns/1ns

module operandFetchTb;

  localparam int halfPeriod = 4;
  localparam int drainLimit = 16;
  localparam int newLine = 10;

  // one issued instruction still waiting for its result
  typedef struct packed {
    coreTypes::word_t instr;
    logic branch;
    logic link;
    coreTypes::regIdx_t rd;
    coreTypes::word_t a;
    coreTypes::word_t b;
    coreTypes::word_t c;
    int dueCycle;
  } pendingOp_t;

  logic clk;
  logic clr;
  logic instrValid;
  coreTypes::word_t instr;
  logic wrEn;
  coreTypes::regIdx_t wrAddr;
  coreTypes::word_t wrData;
  logic pcStep;
  coreTypes::word_t pc;
  logic exValid;
  logic exBranch;
  logic exLink;
  logic [3:0] exOpcode;
  coreTypes::regIdx_t exRd;
  coreTypes::word_t exA;
  coreTypes::word_t exB;
  coreTypes::word_t exC;

  pendingOp_t pending[$];
  int cycle;
  int fd;
  int mismatches;
  int timeouts;
  int otherErrors;

  operandFetch uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  task automatic checkWord(input string what, input coreTypes::word_t got,
                           input coreTypes::word_t want);
    if (got !== want)
    begin
      mismatches++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic checkIdx(input string what, input coreTypes::regIdx_t got,
                          input coreTypes::regIdx_t want);
    if (got !== want)
    begin
      mismatches++;
      $display("Fail at %0t ns: %s is r%0d, expected r%0d", $time, what, got, want);
    end
  endtask

  task automatic checkOpcode(input string what, input logic [3:0] got, input logic [3:0] want);
    if (got !== want)
    begin
      mismatches++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic checkFlag(input string what, input bit got, input bit want);
    if (got != want)
    begin
      mismatches++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // oldest instruction against the ex outputs
  task automatic compareResult();
    pendingOp_t want;
    want = pending.pop_front();
    checkFlag("exBranch", exBranch, want.branch);
    checkWord("exA", exA, want.a);
    checkWord("exB", exB, want.b);
    checkWord("exC", exC, want.c);
    // link only means something for a branch, rd and opcode only for data processing
    if (want.branch)
      checkFlag("exLink", exLink, want.link);
    else
    begin
      checkIdx("exRd", exRd, want.rd);
      // opcode is bits 24 down to 21 of a data-processing word
      checkOpcode("exOpcode", exOpcode, want.instr[24:21]);
    end
  endtask

  // one edge, look at the ex outputs, then inputs back to idle
  task automatic stepClock();
    @(posedge clk);
    #1;
    cycle++;
    if (exValid)
    begin
      if (pending.size() == 0)
      begin
        otherErrors++;
        $display("exValid was high at %0t ns with no instruction in flight", $time);
      end
      else
      begin
        if (pending[0].dueCycle != cycle)
        begin
          otherErrors++;
          $display("a result came out at %0t ns in cycle %0d instead of cycle %0d",
                   $time, cycle, pending[0].dueCycle);
        end
        compareResult();
      end
    end
    else if (pending.size() != 0 && pending[0].dueCycle == cycle)
    begin
      otherErrors++;
      $display("no result came out at %0t ns for instruction %h", $time, pending[0].instr);
      pending.delete(0);
    end
    instrValid = 1'b0;
    wrEn = 1'b0;
    pcStep = 1'b0;
  endtask

  // captured on the next edge, result two edges on
  task automatic issueInstr(input pendingOp_t want);
    want.dueCycle = cycle + 2;
    pending.push_back(want);
    instr = want.instr;
    instrValid = 1'b1;
    stepClock();
  endtask

  task automatic runStimulus(input int file);
    logic [7:0] cmd;
    logic [31:0] f [7];
    pendingOp_t want;
    int ch;
    int got;
    bit stop;
    stop = 1'b0;
    while (!stop && $fscanf(file, " %c", cmd) == 1)
    begin
      case (cmd)
        "#":
        begin
          // comment runs to end of line
          ch = $fgetc(file);
          while (ch != newLine && ch != -1)
            ch = $fgetc(file);
        end
        "W":
        begin
          got = $fscanf(file, "%h %h %h", f[0], f[1], f[2]);
          stop = (got != 3);
          if (!stop)
          begin
            wrEn = 1'b1;
            wrAddr = f[0][3:0];
            wrData = f[1];
            pcStep = f[2][0];
            stepClock();
          end
        end
        "S":
        begin
          pcStep = 1'b1;
          stepClock();
        end
        "P":
        begin
          stop = ($fscanf(file, "%h", f[0]) != 1);
          if (!stop)
            checkWord("pc", pc, f[0]);
        end
        "I":
        begin
          got = $fscanf(file, "%h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
          stop = (got != 7);
          if (!stop)
          begin
            want.instr = f[0];
            want.branch = f[1][0];
            want.link = f[2][0];
            want.rd = f[3][3:0];
            want.a = f[4];
            want.b = f[5];
            want.c = f[6];
            want.dueCycle = 0;
            issueInstr(want);
          end
        end
        default:
          stop = 1'b1;
      endcase
      if (stop)
      begin
        otherErrors++;
        $display("stimulus file could not be read at command %c", cmd);
      end
    end
  endtask

  // let the last instructions leave the pipe
  task automatic drainPending();
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < drainLimit)
    begin
      stepClock();
      waited++;
    end
    if (pending.size() != 0)
    begin
      timeouts++;
      $display("timed out with %0d results still missing", pending.size());
    end
  endtask

  initial
  begin
    clr = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    wrEn = 1'b0;
    wrAddr = '0;
    wrData = '0;
    pcStep = 1'b0;
    cycle = 0;
    mismatches = 0;
    timeouts = 0;
    otherErrors = 0;
    repeat (8) @(posedge clk);
    #1;
    clr = 1'b1;
    fd = $fopen("tb/operandStim.txt", "r");
    if (fd == 0)
    begin
      otherErrors++;
      $display("could not open the stimulus file tb/operandStim.txt");
    end
    else
    begin
      runStimulus(fd);
      $fclose(fd);
      drainPending();
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d other",
             mismatches, timeouts, otherErrors);
    if (mismatches + timeouts + otherErrors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: tb/operandFetch_sva.sv
// assertions bound to the operand-fetch top
// reset state of exValid and the fixed two-edge issue latency
`timescale 1ns/1ns

module operandFetch_sva (
  input logic clk,
  input logic clr,
  input logic instrValid,
  input logic exValid
);

  // nothing leaves the pipe while clr is held
  resetQuiet: assert property (@(posedge clk) !clr |-> !exValid)
    else $error("exValid high while clr is low");

  // every issue shows up exactly two edges later, and nothing else does
  validLatency: assert property (@(posedge clk) disable iff (!clr)
                                 exValid == $past(instrValid, 2))
    else $error("exValid does not follow instrValid by two edges");

endmodule

bind operandFetch operandFetch_sva validChecks (
  .clk        (clk),
  .clr        (clr),
  .instrValid (instrValid),
  .exValid    (exValid)
);

// File: src/operandFetch.sv
// operand-fetch slice top, decode then register read then execute latch
// two edges from instrValid to exValid
`timescale 1ns/1ns

module operandFetch (
  input  logic clk,
  input  logic clr,
  input  logic instrValid,
  input  coreTypes::word_t instr,
  input  logic wrEn,
  input  coreTypes::regIdx_t wrAddr,
  input  coreTypes::word_t wrData,
  input  logic pcStep,
  output coreTypes::word_t pc,
  output logic exValid,
  output logic exBranch,
  output logic exLink,
  output logic [3:0] exOpcode,
  output coreTypes::regIdx_t exRd,
  output coreTypes::word_t exA,
  output coreTypes::word_t exB,
  output coreTypes::word_t exC
);

  // decode to execute fields
  decodeIf decBus ();
  // addresses from decode, values to execute
  readPortIf readBus ();

  regFile regs (
    .clk    (clk),
    .clr    (clr),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .pcStep (pcStep),
    .rd     (readBus),
    .pc     (pc)
  );

  decodeStage decode (
    .clk        (clk),
    .clr        (clr),
    .instrValid (instrValid),
    .instr      (coreTypes::instr_t'(instr)),
    .dec        (decBus),
    .rd         (readBus)
  );

  executeLatch execute (
    .clk      (clk),
    .clr      (clr),
    .dec      (decBus),
    .rd       (readBus),
    .exValid  (exValid),
    .exBranch (exBranch),
    .exLink   (exLink),
    .exOpcode (exOpcode),
    .exRd     (exRd),
    .exA      (exA),
    .exB      (exB),
    .exC      (exC)
  );

endmodule

// File: src/executeLatch.sv
// ID/EX register, picks operands by instruction format and captures them
// with the flags and destination of the instruction
`timescale 1ns/1ns

module executeLatch (
  input  logic clk,
  input  logic clr,
  decodeIf.sink dec,
  readPortIf.dataSide rd,
  output logic exValid,
  output logic exBranch,
  output logic exLink,
  output logic [3:0] exOpcode,
  output coreTypes::regIdx_t exRd,
  output coreTypes::word_t exA,
  output coreTypes::word_t exB,
  output coreTypes::word_t exC
);

  coreTypes::word_t opB;
  coreTypes::word_t opC;

  // port A already carries the pc for a branch
  // B becomes the scaled offset, C is unused so zero
  always_comb
  begin
    opB = dec.isBranch ? dec.offset : rd.dataB;
    opC = dec.isBranch ? '0 : rd.dataC;
  end

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      exValid <= 1'b0;
      exBranch <= 1'b0;
      exLink <= 1'b0;
      exOpcode <= '0;
      exRd <= '0;
      exA <= '0;
      exB <= '0;
      exC <= '0;
    end
    else
    begin
      exValid <= dec.valid;
      // payload holds its last value between instructions
      if (dec.valid)
      begin
        exBranch <= dec.isBranch;
        exLink <= dec.link;
        exOpcode <= dec.opcode;
        exRd <= dec.rd;
        exA <= rd.dataA;
        exB <= opB;
        exC <= opC;
      end
    end
  end

endmodule

// File: src/decodeStage.sv
// IF/ID register, holds the fetched word and splits it by format
// drives read addresses and the decoded fields for the execute latch
`timescale 1ns/1ns

module decodeStage (
  input  logic clk,
  input  logic clr,
  input  logic instrValid,
  input  coreTypes::instr_t instr,
  decodeIf.source dec,
  readPortIf.addrSide rd
);

  logic validQ;
  coreTypes::instr_t instrQ;
  logic branch;

  // valid bit is control, cleared with clr
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
      validQ <= 1'b0;
    else
      validQ <= instrValid;
  end

  // instruction word only moves on a valid issue
  always_ff @(posedge clk)
  begin
    if (instrValid)
      instrQ <= instr;
  end

  // class field sits at the same bits in both views
  assign branch = (instrQ.br.instrClass == coreTypes::branchClass);

  assign dec.valid = validQ;
  assign dec.isBranch = branch;
  assign dec.link = instrQ.br.link;
  assign dec.opcode = instrQ.dp.opcode;
  assign dec.rd = instrQ.dp.rd;

  // offset times four, sign taken from bit 23
  assign dec.offset = {{6{instrQ.br.offset[23]}}, instrQ.br.offset, 2'b00};

  // branch reads the pc through port A
  assign rd.addrA = branch ? coreTypes::regIdx_t'(coreTypes::pcIndex) : instrQ.dp.rn;
  // rm lives in the low nibble of operand
  assign rd.addrB = instrQ.dp.operand[3:0];
  assign rd.addrC = instrQ.dp.rd;

endmodule

// File: src/regFile.sv
// sixteen-entry register file, r15 is the program counter
// one write port, three combinational read ports, pc advance by stride
`timescale 1ns/1ns

module regFile (
  input  logic clk,
  input  logic clr,
  input  logic wrEn,
  input  coreTypes::regIdx_t wrAddr,
  input  coreTypes::word_t wrData,
  input  logic pcStep,
  readPortIf.server rd,
  output coreTypes::word_t pc
);

  coreTypes::word_t regs [coreTypes::regCount];

  // one-hot write enable from the write address
  logic [coreTypes::regCount-1:0] wrSel;

  always_comb
  begin
    for (int i = 0; i < coreTypes::regCount; i++)
    begin
      wrSel[i] = wrEn && (wrAddr == coreTypes::regIdx_t'(i));
    end
  end

  // whole array clears with clr
  // a write to r15 wins over the pc advance
  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < coreTypes::regCount; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < coreTypes::regCount; i++)
      begin
        if (wrSel[i])
        begin
          regs[i] <= wrData;
        end
        else if (pcStep && i == coreTypes::pcIndex)
        begin
          regs[i] <= regs[i] + coreTypes::word_t'(coreTypes::pcStride);
        end
      end
    end
  end

  // three independent read muxes, no write bypass
  // a read in the write cycle sees the old value
  assign rd.dataA = regs[rd.addrA];
  assign rd.dataB = regs[rd.addrB];
  assign rd.dataC = regs[rd.addrC];

  // current pc for the outside
  assign pc = regs[coreTypes::pcIndex];

endmodule

// File: src/readPortIf.sv
// three register read ports, addresses in and values back in the same cycle
`timescale 1ns/1ns

interface readPortIf;

  coreTypes::regIdx_t addrA;
  coreTypes::regIdx_t addrB;
  coreTypes::regIdx_t addrC;
  coreTypes::word_t dataA;
  coreTypes::word_t dataB;
  coreTypes::word_t dataC;

  // register file answers whatever is addressed
  modport server (input addrA, addrB, addrC, output dataA, dataB, dataC);

  // decode stage owns the addresses
  modport addrSide (output addrA, addrB, addrC);

  // execute latch owns the returned values
  modport dataSide (input dataA, dataB, dataC);

endinterface

// File: src/decodeIf.sv
// decoded instruction passed from the IF/ID stage to the ID/EX latch
`timescale 1ns/1ns

interface decodeIf;

  logic valid;
  logic isBranch;
  logic link;
  logic [3:0] opcode;
  coreTypes::regIdx_t rd;
  // already sign extended and scaled by four
  coreTypes::word_t offset;

  modport source (output valid, isBranch, link, opcode, rd, offset);

  modport sink (input valid, isBranch, link, opcode, rd, offset);

endinterface

// File: src/coreTypes.sv
// shared widths, register index, instruction views and class codes
// for the operand-fetch slice of the pipeline
package coreTypes;

  // datapath and register file sizes
  localparam int dataWidth = 32;
  localparam int regCount = 16;

  // r15 doubles as the program counter
  localparam int pcIndex = 15;
  localparam int pcStride = 4;

  // class field value that selects the branch view
  localparam logic [2:0] branchClass = 3'b101;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [3:0] regIdx_t;

  // data-processing view, low nibble of operand names rm
  typedef struct packed {
    logic [3:0] condition;
    logic [2:0] instrClass;
    logic [3:0] opcode;
    logic setFlags;
    regIdx_t rn;
    regIdx_t rd;
    logic [11:0] operand;
  } dpFields_t;

  // branch view, word offset still unscaled
  typedef struct packed {
    logic [3:0] condition;
    logic [2:0] instrClass;
    logic link;
    logic [23:0] offset;
  } brFields_t;

  // one fetched word, read through either format
  typedef union packed {
    dpFields_t dp;
    brFields_t br;
  } instr_t;

endpackage
